/* verif/alu_tests.txt */
# op s1 s2 expected, all hex; op is the operation code or R for random operands
# R lines take operation and operands from the generator, their other columns are ignored
0 00000005 00000003 00000008
0 ffffffff 00000001 00000000
0 7fffffff 00000001 80000000
1 00000003 00000005 fffffffe
1 80000000 00000001 7fffffff
2 f0f0f0f0 ff00ff00 f000f000
3 f0f0f0f0 0f0f0000 fffff0f0
4 aaaaaaaa ffff0000 5555aaaa
5 80000000 7fffffff 00000001
5 7fffffff 80000000 00000000
6 80000000 7fffffff 00000000
6 7fffffff 80000000 00000001
6 00000004 00000004 00000000
7 00000001 00000000 00000001
7 00000001 0000001f 80000000
7 12345678 00000024 23456780
8 80000000 00000001 40000000
8 80000000 0000003f 00000001
9 80000000 00000001 c0000000
9 80000000 0000001f ffffffff
9 7ffffff0 00000004 07ffffff
a 00000007 00000006 0000002a
a ffffffff ffffffff 00000001
b ffffffff ffffffff 00000000
b 80000000 80000000 40000000
b 80000000 7fffffff c0000000
c ffffffff ffffffff ffffffff
c 00000002 ffffffff 00000001
d ffffffff ffffffff fffffffe
d 80000000 00000002 00000001
e 00000010 00000020 00000030
f ffffffff 00000002 00000001
R 00000000 00000000 00000000
R 00000000 00000000 00000000
R 00000000 00000000 00000000
R 00000000 00000000 00000000
R 00000000 00000000 00000000
R 00000000 00000000 00000000

/* src.f */
+incdir+logic
logic/alu_op_pkg.sv
logic/alu_data_pkg.sv
logic/alu_arith_logic.sv
logic/alu_shifter.sv
logic/alu_multiplier.sv
logic/alu_control.sv
logic/alu_top.sv
verif/alu_checker.sv
verif/alu_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the ALU testbench with Verilator, run from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module alu_tb -Mdir obj_dir \
    > build.log 2>&1 \
    && ./obj_dir/Valu_tb > sim.log 2>&1 \
    || echo "build or run returned an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log \
    && { echo "result: PASS"; exit 0; } \
    || { echo "result: FAIL"; exit 1; }

/* verif/alu_tb.sv */
`include "alu_defs.svh"

module alu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                 I_clk;
    logic                 I_reset;
    logic                 I_en;
    logic [`ALU_XLEN-1:0] I_data_s1;
    logic [`ALU_XLEN-1:0] I_data_s2;
    alu_op_pkg::alu_op_t  I_aluop;
    logic [`ALU_XLEN-1:0] O_data;
    logic                 O_busy;
    logic                 O_lt;
    logic                 O_ltu;
    logic                 O_eq;
    logic [`ALU_XLEN-1:0] exp_data;
    logic                 exp_from_file;
    int                   error_count;
    int                   check_count;
    int                   n_tests;
    logic [31:0]          rng;

    logic [3:0]  q_op [$];
    logic        q_rand [$];
    logic [31:0] q_a [$];
    logic [31:0] q_b [$];
    logic [31:0] q_exp [$];

    alu_top dut_i (
        .I_clk(I_clk), .I_reset(I_reset), .I_en(I_en), .I_data_s1(I_data_s1),
        .I_data_s2(I_data_s2), .I_aluop(I_aluop), .O_data(O_data), .O_busy(O_busy),
        .O_lt(O_lt), .O_ltu(O_ltu), .O_eq(O_eq)
    );

    alu_checker checker_i (
        .I_clk(I_clk), .I_reset(I_reset), .I_en(I_en), .I_aluop(I_aluop),
        .I_data_s1(I_data_s1), .I_data_s2(I_data_s2), .exp_data(exp_data),
        .exp_from_file(exp_from_file), .O_data(O_data), .O_busy(O_busy), .O_lt(O_lt),
        .O_ltu(O_ltu), .O_eq(O_eq), .error_count(error_count), .check_count(check_count)
    );

    always #4 I_clk = ~I_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [3:0] hex_digit(input logic [7:0] c);
        if (c >= "a" && c <= "f") begin
            return 4'(c - "a" + 10);
        end
        return 4'(c - "0");
    endfunction

    task automatic load_tests();
        int          fd;
        int          r;
        logic [63:0] tok;
        logic [799:0] rest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        fd = $fopen("verif/alu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file verif/alu_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            tok = '0;
            r = $fscanf(fd, "%s", tok);
            if (r != 1) begin
                break;
            end
            if (tok == "#") begin
                r = $fgets(rest, fd);
            end else begin
                r = $fscanf(fd, "%h %h %h", a, b, e);
                q_rand.push_back(tok == "R");
                q_op.push_back(hex_digit(tok[7:0]));
                q_a.push_back(a);
                q_b.push_back(b);
                q_exp.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // random operands also land between operations so flags and hold get exercised
    task automatic scramble_operands();
        rng = lcg_next(rng);
        I_data_s1 = rng;
        rng = lcg_next(rng);
        I_data_s2 = rng;
    endtask

    task automatic run_one(input int i);
        @(posedge I_clk);
        #1;
        I_en = 1'b1;
        if (q_rand[i]) begin
            rng = lcg_next(rng);
            I_aluop = alu_op_pkg::alu_op_t'(rng[19:16]);
            scramble_operands();
            exp_from_file = 1'b0;
        end else begin
            I_aluop   = alu_op_pkg::alu_op_t'(q_op[i]);
            I_data_s1 = q_a[i];
            I_data_s2 = q_b[i];
            exp_from_file = 1'b1;
        end
        exp_data = q_exp[i];
        @(posedge I_clk);
        #1;
        I_en = 1'b0;
        scramble_operands();
        while (O_busy) begin
            @(posedge I_clk);
            #1;
        end
    endtask

    initial begin
        I_clk         = 1'b0;
        I_reset       = 1'b1;
        I_en          = 1'b0;
        I_data_s1     = '0;
        I_data_s2     = '0;
        I_aluop       = alu_op_pkg::ADD;
        exp_data      = '0;
        exp_from_file = 1'b1;
        rng           = 32'h4b35;
        n_tests       = 0;
        load_tests();
        n_tests = q_op.size();
        repeat (10) @(posedge I_clk);
        #1;
        I_reset = 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            run_one(i);
        end
        repeat (3) @(posedge I_clk);
        $display("errors: %0d, operations checked: %0d of %0d",
                 error_count, check_count, n_tests);
        if (error_count == 0 && check_count == n_tests && n_tests > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // limit scales with the number of tests
    initial begin
        wait (n_tests > 0);
        #((10 + 40 * n_tests) * 8);
        $display("the simulation timed out before all tests finished");
        $display("errors: %0d, operations checked: %0d of %0d",
                 error_count, check_count, n_tests);
        $display("sim failed");
        $finish;
    end

endmodule

/* verif/alu_checker.sv */
`include "alu_defs.svh"

module alu_checker (
    input  logic                 I_clk,
    input  logic                 I_reset,
    input  logic                 I_en,
    input  alu_op_pkg::alu_op_t  I_aluop,
    input  logic [`ALU_XLEN-1:0] I_data_s1,
    input  logic [`ALU_XLEN-1:0] I_data_s2,
    input  logic [`ALU_XLEN-1:0] exp_data,
    input  logic                 exp_from_file,
    input  logic [`ALU_XLEN-1:0] O_data,
    input  logic                 O_busy,
    input  logic                 O_lt,
    input  logic                 O_ltu,
    input  logic                 O_eq,
    output int                   error_count,
    output int                   check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                 pending;
    logic [`ALU_XLEN-1:0] held;
    logic [`ALU_XLEN-1:0] want;
    alu_op_pkg::alu_op_t  c_op;
    logic                 exp_lt;
    logic                 exp_ltu;
    logic                 exp_eq;

    function automatic logic mul_op(input alu_op_pkg::alu_op_t op);
        return (op >= alu_op_pkg::MUL) && (op <= alu_op_pkg::MULHU);
    endfunction

    // reference result straight from the operation definitions
    function automatic logic [31:0] model_result(input alu_op_pkg::alu_op_t op,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (op)
            alu_op_pkg::SUB:    return a - b;
            alu_op_pkg::AND:    return a & b;
            alu_op_pkg::OR:     return a | b;
            alu_op_pkg::XOR:    return a ^ b;
            alu_op_pkg::SLT:    return {31'b0, $signed(a) < $signed(b)};
            alu_op_pkg::SLTU:   return {31'b0, a < b};
            alu_op_pkg::SLL:    return a << b[4:0];
            alu_op_pkg::SRL:    return a >> b[4:0];
            alu_op_pkg::SRA:    return $signed(a) >>> b[4:0];
            alu_op_pkg::MUL:    return a * b;
            alu_op_pkg::MULH: begin
                p = sa * sb;
                return p[63:32];
            end
            alu_op_pkg::MULHSU: begin
                p = sa * $signed(ub);
                return p[63:32];
            end
            alu_op_pkg::MULHU: begin
                p = ua * ub;
                return p[63:32];
            end
            default:            return a + b;
        endcase
    endfunction

    initial begin
        error_count = 0;
        check_count = 0;
        pending     = 1'b0;
        held        = '0;
    end

    // one operation at a time, from the accepting edge to its result
    // pending only changes on rising edges, the hold check runs on falling ones
    initial begin
        forever begin
            @(posedge I_clk);
            pending = 1'b0;
            if (!I_reset && I_en) begin
                c_op    = I_aluop;
                want    = exp_from_file ? exp_data : model_result(I_aluop, I_data_s1, I_data_s2);
                pending = 1'b1;
                @(negedge I_clk);
                if (mul_op(c_op)) begin
                    if (O_busy !== 1'b1) begin
                        $display("ERROR O_busy: expected 1, got %h", O_busy);
                        error_count++;
                    end
                    while (O_busy === 1'b1) begin
                        @(negedge I_clk);
                    end
                end
                if (O_data !== want) begin
                    $display("ERROR O_data (op %0d): expected %h, got %h", c_op, want, O_data);
                    error_count++;
                end
                held = want;
                check_count++;
            end
        end
    end

    // between operations the result holds, busy stays low, flags follow the operands
    always @(negedge I_clk) begin
        exp_lt  = ($signed(I_data_s1) < $signed(I_data_s2));
        exp_ltu = (I_data_s1 < I_data_s2);
        exp_eq  = (I_data_s1 == I_data_s2);
        if (!I_reset) begin
            if (!pending) begin
                if (O_data !== held) begin
                    $display("ERROR O_data (held): expected %h, got %h", held, O_data);
                    error_count++;
                end
                if (O_busy !== 1'b0) begin
                    $display("ERROR O_busy: expected 0, got %h", O_busy);
                    error_count++;
                end
            end
            if (O_lt !== exp_lt) begin
                $display("ERROR O_lt (s1 %h s2 %h): expected %h, got %h",
                         I_data_s1, I_data_s2, exp_lt, O_lt);
                error_count++;
            end
            if (O_ltu !== exp_ltu) begin
                $display("ERROR O_ltu (s1 %h s2 %h): expected %h, got %h",
                         I_data_s1, I_data_s2, exp_ltu, O_ltu);
                error_count++;
            end
            if (O_eq !== exp_eq) begin
                $display("ERROR O_eq (s1 %h s2 %h): expected %h, got %h",
                         I_data_s1, I_data_s2, exp_eq, O_eq);
                error_count++;
            end
        end
    end

endmodule

/* logic/alu_top.sv */
`include "alu_defs.svh"

module alu_top (
    input  logic                 I_clk,
    input  logic                 I_reset,
    input  logic                 I_en,
    input  logic [`ALU_XLEN-1:0] I_data_s1,
    input  logic [`ALU_XLEN-1:0] I_data_s2,
    input  alu_op_pkg::alu_op_t  I_aluop,
    output logic [`ALU_XLEN-1:0] O_data,
    output logic                 O_busy,
    output logic                 O_lt,
    output logic                 O_ltu,
    output logic                 O_eq
);

    logic [`ALU_XLEN-1:0]   sum;
    logic [`ALU_XLEN-1:0]   diff;
    logic [`ALU_XLEN-1:0]   and_res;
    logic [`ALU_XLEN-1:0]   or_res;
    logic [`ALU_XLEN-1:0]   xor_res;
    logic [`ALU_XLEN-1:0]   shift_out;
    logic                   shift_left;
    logic                   shift_arith;
    logic                   mul_start;
    logic                   a_signed;
    logic                   b_signed;
    logic                   done;
    alu_data_pkg::product_t product;

    alu_control u_control (
        .I_clk(I_clk), .I_reset(I_reset), .I_en(I_en), .I_aluop(I_aluop),
        .sum(sum), .diff(diff), .and_res(and_res), .or_res(or_res), .xor_res(xor_res),
        .shift_out(shift_out), .lt(O_lt), .ltu(O_ltu), .eq(O_eq),
        .product(product), .done(done),
        .shift_left(shift_left), .shift_arith(shift_arith), .mul_start(mul_start),
        .a_signed(a_signed), .b_signed(b_signed), .O_data(O_data), .O_busy(O_busy)
    );

    alu_arith_logic u_arith_logic (
        .s1(I_data_s1), .s2(I_data_s2), .sum(sum), .diff(diff), .and_res(and_res),
        .or_res(or_res), .xor_res(xor_res), .lt(O_lt), .ltu(O_ltu), .eq(O_eq)
    );

    // shift amount is the low bits of the second operand
    alu_shifter u_shifter (
        .data(I_data_s1), .shamt(I_data_s2[`ALU_SHW-1:0]), .shift_left(shift_left),
        .shift_arith(shift_arith), .shift_out(shift_out)
    );

    alu_multiplier u_multiplier (
        .I_clk(I_clk), .I_reset(I_reset), .mul_start(mul_start), .a_signed(a_signed),
        .b_signed(b_signed), .a(I_data_s1), .b(I_data_s2), .product(product), .done(done)
    );

endmodule

/* logic/alu_control.sv */
`include "alu_defs.svh"

module alu_control (
    input  logic                  I_clk,
    input  logic                  I_reset,
    input  logic                  I_en,
    input  alu_op_pkg::alu_op_t   I_aluop,
    input  logic [`ALU_XLEN-1:0]  sum,
    input  logic [`ALU_XLEN-1:0]  diff,
    input  logic [`ALU_XLEN-1:0]  and_res,
    input  logic [`ALU_XLEN-1:0]  or_res,
    input  logic [`ALU_XLEN-1:0]  xor_res,
    input  logic [`ALU_XLEN-1:0]  shift_out,
    input  logic                  lt,
    input  logic                  ltu,
    input  logic                  eq,
    input  alu_data_pkg::product_t product,
    input  logic                  done,
    output logic                  shift_left,
    output logic                  shift_arith,
    output logic                  mul_start,
    output logic                  a_signed,
    output logic                  b_signed,
    output logic [`ALU_XLEN-1:0]  O_data,
    output logic                  O_busy
);

    logic                 busy;
    logic                 op_is_mul;
    logic [`ALU_XLEN-1:0] result;
    logic [`ALU_XLEN-1:0] alu_word;
    logic [`ALU_XLEN-1:0] mul_word;
    alu_op_pkg::alu_op_t  op_q;

    // operation decode for the datapath
    assign op_is_mul   = alu_op_pkg::is_mul(I_aluop);
    assign shift_left  = (I_aluop == alu_op_pkg::SLL);
    assign shift_arith = (I_aluop == alu_op_pkg::SRA);
    assign a_signed    = (I_aluop == alu_op_pkg::MULH) || (I_aluop == alu_op_pkg::MULHSU);
    assign b_signed    = (I_aluop == alu_op_pkg::MULH);
    assign mul_start   = I_en & op_is_mul;

    // single cycle result, anything undecoded acts as add
    always_comb begin
        case (I_aluop)
            alu_op_pkg::SUB:  alu_word = diff;
            alu_op_pkg::AND:  alu_word = and_res;
            alu_op_pkg::OR:   alu_word = or_res;
            alu_op_pkg::XOR:  alu_word = xor_res;
            alu_op_pkg::SLT:  alu_word = {{(`ALU_XLEN-1){1'b0}}, lt};
            alu_op_pkg::SLTU: alu_word = {{(`ALU_XLEN-1){1'b0}}, ltu};
            alu_op_pkg::SLL,
            alu_op_pkg::SRL,
            alu_op_pkg::SRA:  alu_word = shift_out;
            default:          alu_word = sum;
        endcase
    end

    // the multiply that was started decides which half is kept
    assign mul_word = (op_q == alu_op_pkg::MUL) ? product.half.lo : product.half.hi;

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            busy   <= 1'b0;
            result <= '0;
        end else if (done) begin
            busy   <= 1'b0;
            result <= mul_word;
        end else if (I_en) begin
            if (op_is_mul) begin
                busy <= 1'b1;
            end else begin
                result <= alu_word;
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (mul_start) begin
            op_q <= I_aluop;
        end
    end

    assign O_data = result;
    assign O_busy = busy;

    // no new operation may be accepted while a multiply runs
    assert property (@(posedge I_clk) disable iff (I_reset) busy |-> !I_en);

    // the multiplier only finishes a multiply that this block started
    assert property (@(posedge I_clk) disable iff (I_reset) done |-> busy);

    assert property (@(posedge I_clk) I_reset |=> !O_busy);

endmodule

/* logic/alu_multiplier.sv */
`include "alu_defs.svh"

module alu_multiplier (
    input  logic                   I_clk,
    input  logic                   I_reset,
    input  logic                   mul_start,
    input  logic                   a_signed,
    input  logic                   b_signed,
    input  logic [`ALU_XLEN-1:0]   a,
    input  logic [`ALU_XLEN-1:0]   b,
    output alu_data_pkg::product_t product,
    output logic                   done
);

    logic [`ALU_XLEN-1:0]   a_mag;
    logic [`ALU_XLEN-1:0]   b_mag;
    logic [`ALU_XLEN-1:0]   mcand;
    logic [`ALU_XLEN:0]     partial;
    logic [`ALU_SHW-1:0]    count;
    logic                   running;
    logic                   neg_q;
    alu_data_pkg::product_t acc;

    // operands treated as signed are reduced to their magnitude
    assign a_mag = (a_signed && a[`ALU_XLEN-1]) ? -a : a;
    assign b_mag = (b_signed && b[`ALU_XLEN-1]) ? -b : b;

    // add the multiplicand into the upper half when the next multiplier bit is set
    assign partial = {1'b0, acc.half.hi} + (acc.half.lo[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge I_clk) begin
        if (mul_start) begin
            mcand    <= a_mag;
            acc.full <= {{`ALU_XLEN{1'b0}}, b_mag};
            neg_q    <= (a_signed & a[`ALU_XLEN-1]) ^ (b_signed & b[`ALU_XLEN-1]);
        end else if (running) begin
            acc.full <= {partial, acc.half.lo[`ALU_XLEN-1:1]};
        end
    end

    // 32 iterations, count runs from all ones down to zero
    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            done <= 1'b0;
            if (mul_start) begin
                running <= 1'b1;
                count   <= '1;
            end else if (running) begin
                count <= count - 1'b1;
                if (count == '0) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // sign correction happens in the cycle that done is high
    assign product.full = neg_q ? -acc.full : acc.full;

    assert property (@(posedge I_clk) disable iff (I_reset) mul_start |-> !running);

endmodule

/* logic/alu_shifter.sv */
`include "alu_defs.svh"

module alu_shifter (
    input  logic [`ALU_XLEN-1:0] data,
    input  logic [`ALU_SHW-1:0]  shamt,
    input  logic                 shift_left,
    input  logic                 shift_arith,
    output logic [`ALU_XLEN-1:0] shift_out
);

    function automatic logic [`ALU_XLEN-1:0] bit_rev(input logic [`ALU_XLEN-1:0] v);
        logic [`ALU_XLEN-1:0] r;
        for (int i = 0; i < `ALU_XLEN; i++) begin
            r[i] = v[`ALU_XLEN-1-i];
        end
        return r;
    endfunction

    logic [`ALU_XLEN-1:0] stage [0:`ALU_SHW];
    logic                 fill;

    // left shifts reuse the right shifter on the mirrored word
    assign fill     = shift_arith & data[`ALU_XLEN-1];
    assign stage[0] = shift_left ? bit_rev(data) : data;

    // stage k moves the word by 2**k when shamt bit k is set
    for (genvar k = 0; k < `ALU_SHW; k++) begin : g_stage
        assign stage[k+1] = shamt[k] ? {{(2**k){fill}}, stage[k][`ALU_XLEN-1:2**k]}
                                     : stage[k];
    end

    assign shift_out = shift_left ? bit_rev(stage[`ALU_SHW]) : stage[`ALU_SHW];

endmodule

/* logic/alu_arith_logic.sv */
`include "alu_defs.svh"

module alu_arith_logic (
    input  logic [`ALU_XLEN-1:0] s1,
    input  logic [`ALU_XLEN-1:0] s2,
    output logic [`ALU_XLEN-1:0] sum,
    output logic [`ALU_XLEN-1:0] diff,
    output logic [`ALU_XLEN-1:0] and_res,
    output logic [`ALU_XLEN-1:0] or_res,
    output logic [`ALU_XLEN-1:0] xor_res,
    output logic                 lt,
    output logic                 ltu,
    output logic                 eq
);

    // one extra bit on top catches the borrow
    logic [`ALU_XLEN:0] sub_ext;

    always_comb begin
        sum     = s1 + s2;
        sub_ext = {1'b0, s1} - {1'b0, s2};
        diff    = sub_ext[`ALU_XLEN-1:0];

        and_res = s1 & s2;
        or_res  = s1 | s2;
        xor_res = s1 ^ s2;

        // borrow alone is the unsigned compare
        ltu = sub_ext[`ALU_XLEN];
        // differing signs flip the sense of the borrow
        lt  = sub_ext[`ALU_XLEN] ^ xor_res[`ALU_XLEN-1];
        eq  = (s1 == s2);

        // the comparator and the subtractor must agree on equality
        assert (eq == (diff == '0))
        else $error("eq flag disagrees with subtractor result");
    end

endmodule

/* logic/alu_data_pkg.sv */
`include "alu_defs.svh"

package alu_data_pkg;

    // upper and lower word of a full product
    typedef struct packed {
        logic [`ALU_XLEN-1:0] hi;
        logic [`ALU_XLEN-1:0] lo;
    } product_half_t;

    // multiplier shifts and negates the full view,
    // control only picks one of the halves
    typedef union packed {
        logic [2*`ALU_XLEN-1:0] full;
        product_half_t          half;
    } product_t;

endpackage

/* logic/alu_op_pkg.sv */
package alu_op_pkg;

    // operation codes as presented on I_aluop
    // codes 14 and 15 are unused and fall back to add
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        SLTU   = 4'd6,
        SLL    = 4'd7,
        SRL    = 4'd8,
        SRA    = 4'd9,
        MUL    = 4'd10,
        MULH   = 4'd11,
        MULHSU = 4'd12,
        MULHU  = 4'd13
    } alu_op_t;

    // true for the four operations that go through the multiplier
    function automatic logic is_mul(input alu_op_t op);
        return (op == MUL) || (op == MULH) || (op == MULHSU) || (op == MULHU);
    endfunction

endpackage

/* logic/alu_defs.svh */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// width of one data word
`define ALU_XLEN 32

// shift amount width, only the low bits of s2 reach the shifter
`define ALU_SHW 5

// a multiply runs one iteration per bit of the word
// and the sign fix-up follows in one more cycle

`endif
